//--- Bender.yml
package:
  name: axi_rd_slave

sources:
  - files:
      - common/axi_rd_pkg.sv
      - verilog/rr_arbiter.sv
      - verilog/id_order.sv
      - rd_slot/burst_addr_gen.sv
      - rd_slot/rd_slot.sv
      - verilog/axi_rd_slave.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/axi_rd_assertions.sv
      - dv/tb_axi_rd.sv

//--- common/axi_rd_pkg.sv
package axi_rd_pkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int ID_WIDTH    = 4;
    localparam int ADDR_WIDTH  = 16;
    localparam int DATA_WIDTH  = 32;
    localparam int LEN_WIDTH   = 8;
    localparam int SIZE_WIDTH  = 3;
    localparam int BURST_WIDTH = 2;
    localparam int RESP_WIDTH  = 2;

    // --------------------
    // Slot sizing and fetch model
    // --------------------
    localparam int MAX_BURST_LEN   = 8;                            // Depth of the slot beat buffer
    localparam int BEAT_CNT_WIDTH  = $clog2(MAX_BURST_LEN + 1);    // Counts 0 to MAX_BURST_LEN
    localparam int FETCH_DELAY     = 24;                           // Base fetch latency in cycles
    localparam int FETCH_CNT_WIDTH = 5;

    localparam int PAD_WIDTH = DATA_WIDTH - ID_WIDTH - ADDR_WIDTH; // Zero bits above id and addr

    // --------------------
    // Protocol codes
    // --------------------
    localparam logic [BURST_WIDTH-1:0] BURST_FIXED = 2'd0;
    localparam logic [BURST_WIDTH-1:0] BURST_INCR  = 2'd1;
    localparam logic [BURST_WIDTH-1:0] BURST_WRAP  = 2'd2;

    localparam logic [RESP_WIDTH-1:0] RESP_OKAY   = 2'd0;
    localparam logic [RESP_WIDTH-1:0] RESP_SLVERR = 2'd2;

    // --------------------
    // Channel payloads
    // --------------------
    typedef struct packed {
        logic [ID_WIDTH-1:0]    id;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [LEN_WIDTH-1:0]   len;      // Beats minus one
        logic [SIZE_WIDTH-1:0]  size;     // Log2 of bytes per beat
        logic [BURST_WIDTH-1:0] burst;
    } ar_req_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        logic [RESP_WIDTH-1:0] resp;
        logic                  last;
    } r_beat_t;

    // Content of a modelled data word
    typedef struct packed {
        logic [PAD_WIDTH-1:0]  pad;
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
    } rdata_rec_t;

    typedef union packed {
        logic [DATA_WIDTH-1:0] raw;       // As seen on the bus
        rdata_rec_t            rec;
    } rdata_word_u;

endpackage

//--- dv/axi_rd_assertions.sv
`timescale 1ns/100ps

module axi_rd_assertions (
    input logic                clk,
    input logic                rst_n,
    input axi_rd_pkg::r_beat_t r_beat,
    input logic                rvalid,
    input logic                rready,
    input logic                arready
);

    int fail_cnt = 0;                       // Failed assertion count

    // --------------------
    // Read data channel
    // --------------------
    property p_beat_held;
        @(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> (rvalid && $stable(r_beat));
    endproperty

    a_beat_held : assert property (p_beat_held)
        else begin
            $error("R beat changed or was withdrawn before rready");
            fail_cnt++;
        end

    a_no_rvalid_in_reset : assert property (@(posedge clk) !rst_n |-> !rvalid)
        else begin
            $error("rvalid high while in reset");
            fail_cnt++;
        end

    // --------------------
    // Read address channel
    // --------------------
    a_arready_after_reset : assert property (@(posedge clk) $rose(rst_n) |-> arready)
        else begin
            $error("arready low in the first cycle after reset");
            fail_cnt++;
        end

endmodule

//--- dv/tb_axi_rd.sv
`timescale 1ns/100ps

module tb_axi_rd;

    localparam int OST_DEPTH    = 4;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int HOLD_CYCLES  = 40;                      // Back-pressure window in test 5
    localparam int TOTAL_BEATS  = 57;                      // Beats over all five tests
    localparam int WATCHDOG_CYCLES =
        TOTAL_BEATS * (axi_rd_pkg::FETCH_DELAY + 10) + RESET_CYCLES + HOLD_CYCLES;

    localparam logic [1:0] RDY_LOW    = 2'd0;
    localparam logic [1:0] RDY_HIGH   = 2'd1;
    localparam logic [1:0] RDY_RANDOM = 2'd2;

    logic                clk;
    logic                rst_n;
    axi_rd_pkg::ar_req_t ar_req;
    logic                arvalid;
    logic                arready;
    axi_rd_pkg::r_beat_t r_beat;
    logic                rvalid;
    logic                rready;

    logic [1:0]          rready_mode;
    int                  seed;
    axi_rd_pkg::r_beat_t exp_q [$];                        // Expected beats in issue order

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    axi_rd_slave #(.OST_DEPTH(OST_DEPTH)) u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar_req  (ar_req),
        .arvalid (arvalid),
        .arready (arready),
        .r_beat  (r_beat),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    bind axi_rd_slave axi_rd_assertions u_assertions (
        .clk     (clk),
        .rst_n   (rst_n),
        .r_beat  (r_beat),
        .rvalid  (rvalid),
        .rready  (rready),
        .arready (arready)
    );

    // --------------------
    // Error handling
    // --------------------
    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h",
                                    $time, name, actual, expected));
        end
    endtask

    always @(negedge clk) begin : assertion_watch
        if (u_dut.u_assertions.fail_cnt != 0) begin
            stop_on_error("A protocol assertion on the DUT ports failed");
        end
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [15:0] beat_addr(input axi_rd_pkg::ar_req_t req, input int beat);
        int bytes;
        int total;
        int base;
        bytes = 1 << req.size;
        total = bytes * (int'(req.len) + 1);
        if (req.burst == axi_rd_pkg::BURST_FIXED) begin
            return req.addr;
        end else if (req.burst == axi_rd_pkg::BURST_WRAP) begin
            base = (int'(req.addr) / total) * total;       // Lower wrap boundary
            return 16'(base + ((int'(req.addr) - base + beat * bytes) % total));
        end else if (beat == 0) begin
            return req.addr;
        end else begin
            return 16'((int'(req.addr) / bytes) * bytes + beat * bytes);
        end
    endfunction

    function automatic axi_rd_pkg::ar_req_t make_req(input logic [3:0] id,
                                                     input logic [15:0] addr,
                                                     input logic [7:0] len,
                                                     input logic [2:0] size,
                                                     input logic [1:0] burst);
        axi_rd_pkg::ar_req_t req;
        req.id    = id;
        req.addr  = addr;
        req.len   = len;
        req.size  = size;
        req.burst = burst;
        return req;
    endfunction

    task automatic push_expected(input axi_rd_pkg::ar_req_t req);
        axi_rd_pkg::r_beat_t     b;
        axi_rd_pkg::rdata_word_u w;
        for (int i = 0; i <= int'(req.len); i++) begin
            w.rec.pad  = '0;
            w.rec.id   = req.id;
            w.rec.addr = beat_addr(req, i);
            b.id       = req.id;
            b.data     = w.raw;
            b.last     = (i == int'(req.len));
            b.resp     = (req.id == 4'd15 && b.last) ? axi_rd_pkg::RESP_SLVERR
                                                      : axi_rd_pkg::RESP_OKAY;
            exp_q.push_back(b);
        end
    endtask

    // --------------------
    // Drivers and monitor
    // --------------------
    // Called on a rising edge, returns on the edge of the transfer
    task automatic send_request(input axi_rd_pkg::ar_req_t req);
        ar_req  <= req;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        push_expected(req);
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    always @(posedge clk) begin : rready_drive
        case (rready_mode)
            RDY_LOW:  rready <= 1'b0;
            RDY_HIGH: rready <= 1'b1;
            default:  rready <= (($random(seed) & 3) != 0);   // Stall about one beat in four
        endcase
    end

    // Compare with the oldest expected beat of the same ID
    always @(negedge clk) begin : beat_monitor
        int                      idx;
        axi_rd_pkg::r_beat_t     exp_b;
        axi_rd_pkg::rdata_word_u got_w;
        axi_rd_pkg::rdata_word_u exp_w;
        if (rst_n && rvalid && rready) begin
            idx = -1;
            for (int k = 0; k < exp_q.size(); k++) begin
                if (idx < 0 && exp_q[k].id == r_beat.id) begin
                    idx = k;
                end
            end
            if (idx < 0) begin
                stop_on_error($sformatf(
                    "Read beat with ID %0d arrived at %0t ns with no request open",
                    r_beat.id, $time));
            end else begin
                exp_b = exp_q[idx];
                exp_q.delete(idx);
                got_w.raw = r_beat.data;
                exp_w.raw = exp_b.data;
                check_value("r_beat.data.pad", got_w.rec.pad, exp_w.rec.pad);
                check_value("r_beat.data.id", got_w.rec.id, exp_w.rec.id);
                check_value("r_beat.data.addr", got_w.rec.addr, exp_w.rec.addr);
                check_value("r_beat.resp", r_beat.resp, exp_b.resp);
                check_value("r_beat.last", r_beat.last, exp_b.last);
            end
        end
    end

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_incr_burst();
        $display("Test 1: INCR burst");
        rready_mode <= RDY_HIGH;
        send_request(make_req(4'd3, 16'h0040, 8'd3, 3'd2, axi_rd_pkg::BURST_INCR));
        wait_drained();
    endtask

    task automatic test_fixed_wrap();
        $display("Test 2: FIXED and WRAP bursts");
        send_request(make_req(4'd5, 16'h0200, 8'd3, 3'd2, axi_rd_pkg::BURST_FIXED));
        send_request(make_req(4'd6, 16'h0108, 8'd3, 3'd2, axi_rd_pkg::BURST_WRAP));
        wait_drained();
    endtask

    task automatic test_error_inject();
        $display("Test 3: slave error on ID 15");
        send_request(make_req(4'd15, 16'h0400, 8'd3, 3'd2, axi_rd_pkg::BURST_INCR));
        wait_drained();
        send_request(make_req(4'd14, 16'h0400, 8'd3, 3'd2, axi_rd_pkg::BURST_INCR));
        wait_drained();
    endtask

    task automatic test_outstanding_order();
        $display("Test 4: outstanding requests and ID ordering");
        send_request(make_req(4'd2, 16'h0800, 8'd1, 3'd2, axi_rd_pkg::BURST_INCR));
        send_request(make_req(4'd7, 16'h0306, 8'd2, 3'd1, axi_rd_pkg::BURST_INCR));
        send_request(make_req(4'd2, 16'h0900, 8'd3, 3'd2, axi_rd_pkg::BURST_WRAP));
        send_request(make_req(4'd9, 16'h0A00, 8'd7, 3'd2, axi_rd_pkg::BURST_INCR));
        wait_drained();
    endtask

    task automatic test_full_table();
        $display("Test 5: full table and back-pressure");
        rready_mode <= RDY_LOW;
        send_request(make_req(4'd1, 16'h1000, 8'd3, 3'd2, axi_rd_pkg::BURST_INCR));
        send_request(make_req(4'd4, 16'h1100, 8'd3, 3'd2, axi_rd_pkg::BURST_WRAP));
        send_request(make_req(4'd1, 16'h1200, 8'd3, 3'd2, axi_rd_pkg::BURST_INCR));
        send_request(make_req(4'd12, 16'h1300, 8'd3, 3'd0, axi_rd_pkg::BURST_INCR));
        fork
            send_request(make_req(4'd4, 16'h1400, 8'd3, 3'd2, axi_rd_pkg::BURST_FIXED));
            begin
                repeat (HOLD_CYCLES) begin
                    @(negedge clk);
                    check_value("arready", arready, 0);   // Every slot is busy
                end
                check_value("rvalid", rvalid, 1);
                @(posedge clk);
                rready_mode <= RDY_RANDOM;
            end
        join
        wait_drained();
        @(negedge clk);
        repeat (2 * OST_DEPTH) begin                       // Release and set pointer settle
            if (!arready) begin
                @(negedge clk);
            end
        end
        check_value("arready", arready, 1);
        @(posedge clk);
    endtask

    // --------------------
    // Run control
    // --------------------
    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error($sformatf("Timeout: tests did not finish within %0d cycles",
                                WATCHDOG_CYCLES));
    end

    initial begin : main
        seed        = 22865;
        rready_mode = RDY_LOW;
        ar_req      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        test_incr_burst();
        test_fixed_wrap();
        test_error_inject();
        test_outstanding_order();
        test_full_table();
        @(negedge clk);
        if (u_dut.u_assertions.fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;                       // Held from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- rd_slot/burst_addr_gen.sv
`timescale 1ns/100ps

module burst_addr_gen (
    input  logic [axi_rd_pkg::ADDR_WIDTH-1:0]     start_addr,
    input  logic [axi_rd_pkg::SIZE_WIDTH-1:0]     size,
    input  logic [axi_rd_pkg::LEN_WIDTH-1:0]      len,
    input  logic [axi_rd_pkg::BURST_WIDTH-1:0]    burst,
    input  logic [axi_rd_pkg::ADDR_WIDTH-1:0]     curr_addr,
    input  logic [axi_rd_pkg::BEAT_CNT_WIDTH-1:0] index,       // Beat being fetched now
    input  logic                                  wrapped,
    output logic [axi_rd_pkg::ADDR_WIDTH-1:0]     next_addr,
    output logic                                  wrap_hit
);

    typedef logic [axi_rd_pkg::ADDR_WIDTH-1:0] addr_t;

    addr_t beat_bytes;
    addr_t total_bytes;
    addr_t aligned_addr;
    addr_t wrap_base;
    addr_t wrap_limit;
    addr_t step;

    assign beat_bytes   = addr_t'(1) << size;
    assign total_bytes  = (addr_t'(len) + 1'b1) << size;           // Power of two for WRAP
    assign aligned_addr = start_addr & ~(beat_bytes - 1'b1);
    assign wrap_base    = start_addr & ~(total_bytes - 1'b1);
    assign wrap_limit   = wrap_base + total_bytes;
    assign step         = (addr_t'(index) + 1'b1) << size;         // Offset of the following beat

    // A wrap burst turns around at most once
    assign wrap_hit = (burst == axi_rd_pkg::BURST_WRAP) && !wrapped &&
                      ((curr_addr + beat_bytes) == wrap_limit);

    always_comb begin
        case (burst)
            axi_rd_pkg::BURST_FIXED: begin
                next_addr = start_addr;
            end
            axi_rd_pkg::BURST_INCR: begin
                next_addr = aligned_addr + step;
            end
            axi_rd_pkg::BURST_WRAP: begin
                if (wrap_hit) begin
                    next_addr = wrap_base;                          // Back to the lower limit
                end else if (wrapped) begin
                    next_addr = aligned_addr + step - total_bytes;
                end else begin
                    next_addr = aligned_addr + step;
                end
            end
            default: begin
                next_addr = start_addr;
            end
        endcase
    end

endmodule

//--- rd_slot/rd_slot.sv
`timescale 1ns/100ps

module rd_slot (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                capture,      // Take req into this slot
    input  axi_rd_pkg::ar_req_t req,
    input  logic                beat_taken,   // Beat on the output accepted
    input  logic                release_en,
    output logic                busy,
    output logic                beat_ready,
    output logic                done,
    output axi_rd_pkg::r_beat_t beat
);

    localparam int MAX_LEN   = axi_rd_pkg::MAX_BURST_LEN;
    localparam int BUF_IDX_W = $clog2(MAX_LEN);

    typedef logic [axi_rd_pkg::BEAT_CNT_WIDTH-1:0]  beat_cnt_t;
    typedef logic [axi_rd_pkg::FETCH_CNT_WIDTH-1:0] fetch_cnt_t;

    logic                                  busy_q;
    logic                                  result_q;     // Beat at sent_cnt_q is buffered
    logic                                  comp_q;       // Last beat not yet accepted
    logic                                  wrapped_q;
    axi_rd_pkg::ar_req_t                   req_q;
    beat_cnt_t                             fetch_idx_q;
    beat_cnt_t                             sent_cnt_q;
    beat_cnt_t                             sent_nxt;
    fetch_cnt_t                            fetch_cnt_q;
    fetch_cnt_t                            fetch_target;
    logic [axi_rd_pkg::ADDR_WIDTH-1:0]     curr_addr_q;
    logic [axi_rd_pkg::ADDR_WIDTH-1:0]     next_addr;
    logic                                  wrap_hit;
    logic                                  fetch;
    logic                                  more_beats;
    logic                                  next_vld;
    logic                                  fetch_err;
    logic                                  is_last;
    logic [MAX_LEN-1:0]                    vld_q;
    axi_rd_pkg::rdata_word_u               data_buf [MAX_LEN];
    logic [axi_rd_pkg::RESP_WIDTH-1:0]     resp_buf [MAX_LEN];
    axi_rd_pkg::rdata_word_u               fetch_word;

    burst_addr_gen u_addr_gen (
        .start_addr (req_q.addr),
        .size       (req_q.size),
        .len        (req_q.len),
        .burst      (req_q.burst),
        .curr_addr  (curr_addr_q),
        .index      (fetch_idx_q),
        .wrapped    (wrapped_q),
        .next_addr  (next_addr),
        .wrap_hit   (wrap_hit)
    );

    // --------------------
    // Fetch timing
    // --------------------
    assign fetch_target = fetch_cnt_t'(axi_rd_pkg::FETCH_DELAY - req_q.id);   // Higher ID is faster
    assign fetch        = busy_q && (fetch_cnt_q == fetch_target);
    assign more_beats   = fetch_idx_q < req_q.len;
    assign fetch_err    = (req_q.id == '1) && (fetch_idx_q == req_q.len);
    assign sent_nxt     = sent_cnt_q + 1'b1;
    assign next_vld     = (sent_nxt < MAX_LEN) && vld_q[sent_nxt[BUF_IDX_W-1:0]];
    assign is_last      = sent_cnt_q == req_q.len;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_cnt_q <= '0;
        end else if (capture) begin
            fetch_cnt_q <= fetch_cnt_t'(1);
        end else if (fetch) begin
            fetch_cnt_q <= more_beats ? fetch_cnt_t'(1) : '0;    // Stop after the last beat
        end else if (fetch_cnt_q != '0) begin
            fetch_cnt_q <= fetch_cnt_q + 1'b1;
        end
    end

    // --------------------
    // Slot state
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            comp_q <= 1'b0;
        end else if (capture) begin
            busy_q <= 1'b1;
            comp_q <= 1'b1;
        end else begin
            if (release_en) begin
                busy_q <= 1'b0;
            end
            if (beat_taken && is_last) begin
                comp_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_q <= 1'b0;
        end else if (capture) begin
            result_q <= 1'b0;
        end else if (beat_taken && !is_last && next_vld) begin
            result_q <= 1'b1;                                     // Next beat already here
        end else if (fetch) begin
            result_q <= 1'b1;
        end else if (beat_taken) begin
            result_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_idx_q <= '0;
            sent_cnt_q  <= '0;
            wrapped_q   <= 1'b0;
            vld_q       <= '0;
        end else if (capture) begin
            fetch_idx_q <= '0;
            sent_cnt_q  <= '0;
            wrapped_q   <= 1'b0;
            vld_q       <= '0;
        end else begin
            if (fetch) begin
                fetch_idx_q                       <= fetch_idx_q + 1'b1;
                wrapped_q                         <= wrapped_q | wrap_hit;
                vld_q[fetch_idx_q[BUF_IDX_W-1:0]] <= 1'b1;
            end
            if (beat_taken) begin
                sent_cnt_q <= sent_nxt;
            end
        end
    end

    // --------------------
    // Request copy and beat buffer
    // --------------------
    always_comb begin
        fetch_word.rec.pad  = '0;
        fetch_word.rec.id   = req_q.id;
        fetch_word.rec.addr = curr_addr_q;
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            req_q       <= req;
            curr_addr_q <= req.addr;                              // First beat at the start address
        end else if (fetch) begin
            curr_addr_q                          <= next_addr;
            data_buf[fetch_idx_q[BUF_IDX_W-1:0]] <= fetch_word;
            resp_buf[fetch_idx_q[BUF_IDX_W-1:0]] <= fetch_err ? axi_rd_pkg::RESP_SLVERR
                                                              : axi_rd_pkg::RESP_OKAY;
        end
    end

    assign beat = '{id:   req_q.id,
                    data: data_buf[sent_cnt_q[BUF_IDX_W-1:0]].raw,
                    resp: resp_buf[sent_cnt_q[BUF_IDX_W-1:0]],
                    last: is_last};

    assign busy       = busy_q;
    assign beat_ready = result_q;
    assign done       = busy_q && !result_q && !comp_q;          // Ready for release

endmodule

//--- tb.f
common/axi_rd_pkg.sv
verilog/rr_arbiter.sv
verilog/id_order.sv
rd_slot/burst_addr_gen.sv
rd_slot/rd_slot.sv
verilog/axi_rd_slave.sv
dv/tb_clk_gen.sv
dv/axi_rd_assertions.sv
dv/tb_axi_rd.sv

//--- verilog/axi_rd_slave.sv
`timescale 1ns/100ps

module axi_rd_slave #(
    parameter int OST_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  axi_rd_pkg::ar_req_t ar_req,
    input  logic                arvalid,
    output logic                arready,
    output axi_rd_pkg::r_beat_t r_beat,
    output logic                rvalid,
    input  logic                rready
);

    localparam int SLOT_W = (OST_DEPTH > 1) ? $clog2(OST_DEPTH) : 1;

    logic [OST_DEPTH-1:0] slot_busy;
    logic [OST_DEPTH-1:0] slot_ready;
    logic [OST_DEPTH-1:0] slot_done;
    logic [OST_DEPTH-1:0] eligible;
    logic [OST_DEPTH-1:0] free_vec;
    logic [OST_DEPTH-1:0] ret_vec;
    axi_rd_pkg::r_beat_t  slot_beat [OST_DEPTH];
    logic [SLOT_W-1:0]    set_ptr;
    logic [SLOT_W-1:0]    rel_ptr;
    logic [SLOT_W-1:0]    res_ptr;
    logic                 ar_fire;
    logic                 r_fire;
    logic                 rel_fire;

    assign free_vec = ~slot_busy;
    assign ret_vec  = slot_ready & eligible;                 // Beat buffered and oldest of its ID

    assign arready  = free_vec[set_ptr];                     // Set pointer rests on a free slot
    assign ar_fire  = arvalid && arready;
    assign rel_fire = slot_done[rel_ptr];
    assign rvalid   = ret_vec[res_ptr];
    assign r_beat   = slot_beat[res_ptr];
    assign r_fire   = rvalid && rready;

    // --------------------
    // Slot pointers
    // --------------------
    rr_arbiter #(.WIDTH(OST_DEPTH)) u_set_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (free_vec),
        .advance (ar_fire),
        .ptr     (set_ptr)
    );

    rr_arbiter #(.WIDTH(OST_DEPTH)) u_rel_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (slot_done),
        .advance (rel_fire),
        .ptr     (rel_ptr)
    );

    rr_arbiter #(.WIDTH(OST_DEPTH)) u_res_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (ret_vec),
        .advance (r_fire),
        .ptr     (res_ptr)
    );

    // --------------------
    // Outstanding slots
    // --------------------
    for (genvar i = 0; i < OST_DEPTH; i++) begin : g_slot
        rd_slot u_slot (
            .clk        (clk),
            .rst_n      (rst_n),
            .capture    (ar_fire && (set_ptr == SLOT_W'(i))),
            .req        (ar_req),
            .beat_taken (r_fire && (res_ptr == SLOT_W'(i))),
            .release_en (rel_fire && (rel_ptr == SLOT_W'(i))),
            .busy       (slot_busy[i]),
            .beat_ready (slot_ready[i]),
            .done       (slot_done[i]),
            .beat       (slot_beat[i])
        );
    end

    id_order #(.DEPTH(OST_DEPTH)) u_id_order (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (ar_fire),
        .push_id   (ar_req.id),
        .push_slot (set_ptr),
        .pop       (r_fire),
        .pop_id    (r_beat.id),
        .pop_last  (r_beat.last),
        .eligible  (eligible)
    );

endmodule

//--- verilog/id_order.sv
`timescale 1ns/100ps

module id_order #(
    parameter int   DEPTH  = 4,
    localparam int  SLOT_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            push,
    input  logic [axi_rd_pkg::ID_WIDTH-1:0] push_id,
    input  logic [SLOT_W-1:0]               push_slot,
    input  logic                            pop,
    input  logic [axi_rd_pkg::ID_WIDTH-1:0] pop_id,
    input  logic                            pop_last,
    output logic [DEPTH-1:0]                eligible
);

    // At most DEPTH-1 older requests can share an ID
    typedef logic [SLOT_W-1:0] age_t;

    logic [DEPTH-1:0]                active_q;    // Request still has beats to return
    logic [axi_rd_pkg::ID_WIDTH-1:0] tag_q [DEPTH];
    age_t                            age_q [DEPTH];
    age_t                            push_age;
    logic                            retire;

    assign retire = pop && pop_last;

    // --------------------
    // Age of an incoming request
    // --------------------
    always_comb begin
        push_age = '0;
        for (int k = 0; k < DEPTH; k++) begin
            if (active_q[k] && (tag_q[k] == push_id)) begin
                push_age = push_age + 1'b1;
            end
        end
        if (retire && (pop_id == push_id)) begin
            push_age = push_age - 1'b1;               // Oldest one leaves this cycle
        end
    end

    // --------------------
    // Per slot bookkeeping
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= '0;
            for (int k = 0; k < DEPTH; k++) begin
                age_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < DEPTH; k++) begin
                if (retire && active_q[k] && (tag_q[k] == pop_id)) begin
                    if (age_q[k] == '0) begin
                        active_q[k] <= 1'b0;          // This was the oldest
                    end else begin
                        age_q[k] <= age_q[k] - 1'b1;
                    end
                end
                if (push && (push_slot == SLOT_W'(k))) begin
                    active_q[k] <= 1'b1;
                    age_q[k]    <= push_age;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < DEPTH; k++) begin
            if (push && (push_slot == SLOT_W'(k))) begin
                tag_q[k] <= push_id;
            end
        end
    end

    always_comb begin
        for (int k = 0; k < DEPTH; k++) begin
            eligible[k] = active_q[k] && (age_q[k] == '0);
        end
    end

endmodule

//--- verilog/rr_arbiter.sv
`timescale 1ns/100ps

module rr_arbiter #(
    parameter int   WIDTH = 4,
    localparam int  PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] req,
    input  logic             advance,
    output logic [PTR_W-1:0] ptr
);

    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] ptr_nxt;

    // Nearest requester after the current pointer, searched circularly
    always_comb begin : next_sel
        int idx;
        ptr_nxt = ptr_q;
        for (int k = WIDTH; k >= 1; k--) begin
            idx = (int'(ptr_q) + k) % WIDTH;
            if (req[idx]) begin
                ptr_nxt = PTR_W'(idx);               // Smallest distance wins
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (advance || !req[ptr_q]) begin  // Served or request withdrawn
            ptr_q <= ptr_nxt;
        end
    end

    assign ptr = ptr_q;

endmodule
